// File: Makefile
SIM      := verilator
FLAGS    := --timing --assert
TOP      := cache_tb
FILELIST := sources.f
RUNARGS  := +verilator+error+limit+1000
PASS_MSG := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(RUNARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: dv/cache_assert.sv
`timescale 1ns/100ps

module cache_assert (
    input logic             clk,
    input logic             rst_n,
    input logic             req,
    input logic             ack,
    input cache_pkg::line_t rdata,
    input logic             hit,
    input cache_pkg::way_t  way,
    input logic             dirty,
    input cache_pkg::addr_t victim_addr
);
    int fail_count = 0;   // failed assertions so far

    // ack only answers a sampled request
    assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req))
        else begin
            fail_count++;
            $error("ack rose while req was low");
        end

    // request, lookup, update, then ack is seen
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |-> !ack ##1 !ack ##1 !ack ##1 ack)
        else begin
            fail_count++;
            $error("ack did not rise three edges after req");
        end

    assert property (@(posedge clk) disable iff (!rst_n) $fell(req) |-> ##1 !ack)
        else begin
            fail_count++;
            $error("ack stayed high after req was released");
        end

    // results hold for the whole ack phase
    assert property (@(posedge clk) disable iff (!rst_n)
        ack && $past(ack) |-> $stable(rdata) && $stable(hit) && $stable(way)
            && $stable(dirty) && $stable(victim_addr))
        else begin
            fail_count++;
            $error("outputs changed while ack was high");
        end

endmodule

bind cache_top cache_assert i_cache_assert (.*);

// File: dv/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;
    import cache_pkg::*;

    localparam int TIMEOUT     = 20;   // cycles for each handshake wait
    localparam int HOLD_CYCLES = 2;    // req kept high after ack, stretches DONE

    logic  clk;
    logic  rst_n;
    logic  req;
    op_t   op;
    addr_t addr;
    line_t wdata;
    logic  ack;
    line_t rdata;
    logic  hit;
    way_t  way;
    logic  dirty;
    addr_t victim_addr;

    // reference model, [set][way]
    tag_t     m_tag   [NUM_SETS][NUM_WAYS];
    line_t    m_line  [NUM_SETS][NUM_WAYS];
    way_vec_t m_valid [NUM_SETS];
    way_vec_t m_dirty [NUM_SETS];
    plru_t    m_tree  [NUM_SETS];

    int   errors   = 0;
    int   timeouts = 0;
    way_t got_way;   // way reported by the last access

    cache_top i_cache_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // tree walk, 0 picks the lower half
    function automatic way_t victim_of(plru_t t);
        logic hi;
        logic mid;
        int   leaf;
        hi   = t[0];
        mid  = hi ? t[2] : t[1];
        leaf = 3 + 2 * int'(hi) + int'(mid);
        return {hi, mid, t[leaf]};
    endfunction

    // nodes on the path of w point away from it
    function automatic plru_t touched(plru_t t, way_t w);
        plru_t n;
        n = t;
        n[0] = ~w[2];
        n[1 + int'(w[2])] = ~w[1];
        n[3 + int'(w[2:1])] = ~w[0];
        return n;
    endfunction

    function automatic addr_t set5_addr(tag_t t);
        return {t, 3'd5, 5'd0};
    endfunction

    task automatic check(string name, string field, logic [255:0] exp, logic [255:0] act);
        assert (act === exp) else begin
            errors++;
            $display("mismatch %s %s expected %0h actual %0h", name, field, exp, act);
        end
    endtask

    task automatic access(string name, op_t o, addr_t a, line_t d);
        index_t s;
        tag_t   t;
        way_t   tgt;
        logic   hv;
        int     n;
        s   = a[OFFSET_BITS +: INDEX_BITS];
        t   = a[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
        hv  = 1'b0;
        tgt = victim_of(m_tree[s]);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                hv  = 1'b1;
                tgt = way_t'(w);
            end
        end
        @(negedge clk);
        req   = 1'b1;
        op    = o;
        addr  = a;
        wdata = d;
        n = 0;
        while (!ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ack) begin
            timeouts++;
            $display("%s: no ack from the cache within %0d cycles", name, TIMEOUT);
        end else begin
            got_way = way;
            check(name, "hit", 256'(hv), 256'(hit));
            check(name, "way", 256'(tgt), 256'(way));
            if (!(o == OP_WRITE && hv)) begin
                check(name, "dirty", 256'(m_dirty[s][tgt]), 256'(dirty));
            end
            if (hv && o != OP_WRITE && o != OP_FILL) begin
                check(name, "rdata", m_line[s][tgt], rdata);
            end
            if (m_valid[s][tgt] && (!hv || o == OP_FILL)) begin
                check(name, "victim_addr", 256'({m_tag[s][tgt], s, 5'd0}), 256'(victim_addr));
            end
            repeat (HOLD_CYCLES) @(negedge clk);   // slow release of req
        end
        req = 1'b0;
        n = 0;
        while (ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            timeouts++;
            $display("%s: ack stayed high after req was dropped", name);
        end
        if (o == OP_FILL) begin
            m_tag[s][tgt]   = t;
            m_line[s][tgt]  = d;
            m_valid[s][tgt] = 1'b1;
            m_dirty[s][tgt] = 1'b0;
        end else if (o == OP_WRITE && hv) begin
            m_line[s][tgt]  = d;
            m_dirty[s][tgt] = 1'b1;
        end
        if (hv || o == OP_FILL) begin
            m_tree[s] = touched(m_tree[s], tgt);
        end
    endtask

    initial begin
        way_t order [8];
        way_t miss_way;
        order = '{3'd0, 3'd4, 3'd2, 3'd6, 3'd1, 3'd5, 3'd3, 3'd7};
        rst_n = 1'b0;
        req   = 1'b0;
        op    = OP_READ;
        addr  = '0;
        wdata = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[s] = '0;
            m_dirty[s] = '0;
            m_tree[s]  = '0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check("reset", "ack", 256'(1'b0), 256'(ack));

        access("read_miss", OP_READ, set5_addr(24'h000100), '0);
        for (int i = 0; i < 8; i++) begin
            access("fill_order", OP_FILL, set5_addr(24'h00A000 + 24'(i)),
                   {8{32'h1111_0000 + 32'(i)}});
            check("fill_order", "way", 256'(order[i]), 256'(got_way));
        end
        for (int i = 0; i < 8; i++) begin
            access("read_back", OP_READ, set5_addr(24'h00A000 + 24'(i)), '0);
        end

        access("write_hit", OP_WRITE, set5_addr(24'h00A000), {8{32'hDEAD_BEEF}});
        access("write_hit_read", OP_READ, set5_addr(24'h00A000), '0);
        for (int i = 1; i < 8; i++) begin   // steers the tree back to the dirty way
            access("retouch", OP_READ, set5_addr(24'h00A000 + 24'(i)), '0);
        end
        access("evict", OP_FILL, set5_addr(24'h00B000), {8{32'h2222_0000}});

        access("write_miss", OP_WRITE, set5_addr(24'h00C000), {8{32'h3333_0000}});
        miss_way = got_way;
        access("write_miss_read", OP_READ, set5_addr(24'h00C000), '0);
        check("write_miss_read", "same_victim", 256'(miss_way), 256'(got_way));

        repeat (2) @(negedge clk);
        $display("errors: %0d mismatches, %0d assertion failures, %0d timeouts",
                 errors, i_cache_top.i_cache_assert.fail_count, timeouts);
        if (errors == 0 && timeouts == 0 && i_cache_top.i_cache_assert.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
src/cache_pkg.sv
src/way_access_if.sv
src/cache_ctrl.sv
src/meta_array.sv
src/data_array.sv
src/plru_tree.sv
src/cache_top.sv
dv/cache_assert.sv
dv/cache_tb.sv

// File: src/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  cache_pkg::op_t    op,
    input  cache_pkg::addr_t  addr,
    input  cache_pkg::line_t  wdata,
    output logic              ack,
    output cache_pkg::line_t  rdata,
    output logic              hit,
    output cache_pkg::way_t   way,
    output logic              dirty,
    output cache_pkg::addr_t  victim_addr,
    way_access_if.ctrl        acc
);
    import cache_pkg::*;

    ctrl_state_t state;

    op_t   op_q;
    addr_t addr_q;
    line_t wdata_q;

    logic  any_hit;
    way_t  hit_way;
    way_t  target;
    logic  is_write;
    logic  is_fill;
    logic  in_update;
    logic  wr_en;

    // handshake and sequencing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: state <= UPDATE;   // arrays register the set here
                UPDATE: begin
                    state <= DONE;
                    ack   <= 1'b1;
                end
                DONE: begin
                    if (!req) begin        // release seen
                        state <= IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request capture
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            op_q    <= op;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    // one-hot hit vector to way number
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (acc.hit_ways[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign any_hit   = |acc.hit_ways;
    assign target    = any_hit ? hit_way : acc.victim;
    assign is_write  = (op_q == OP_WRITE);
    assign is_fill   = (op_q == OP_FILL);
    assign in_update = (state == UPDATE);
    assign wr_en     = in_update && (is_fill || (is_write && any_hit));

    assign acc.index     = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign acc.tag       = addr_q[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    assign acc.sel_way   = target;
    assign acc.wr_tag_en = is_fill;   // fill installs a new tag
    assign acc.wr_dirty  = !is_fill;  // write hit marks dirty, fill cleans
    assign acc.wr_line   = wdata_q;
    assign acc.touch     = in_update && (any_hit || is_fill);

    always_comb begin
        acc.wr_ways         = '0;
        acc.wr_ways[target] = wr_en;
    end

    // results taken from the pre-write view of the target
    always_ff @(posedge clk) begin
        if (in_update) begin
            rdata       <= acc.rd_line;
            hit         <= any_hit;
            way         <= target;
            dirty       <= acc.sel_dirty;
            victim_addr <= {acc.sel_tag, acc.index, {OFFSET_BITS{1'b0}}};
        end
    end

endmodule

// File: src/cache_pkg.sv
package cache_pkg;

    // address split: tag | index | offset
    localparam int OFFSET_BITS = 5;   // byte within a 32-byte line
    localparam int INDEX_BITS  = 3;
    localparam int TAG_BITS    = 24;

    localparam int NUM_WAYS = 8;
    localparam int NUM_SETS = 8;

    typedef logic [31:0]  addr_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [255:0] line_t;
    typedef logic [2:0]   way_t;
    typedef logic [NUM_WAYS-1:0]   way_vec_t;  // one bit per way
    typedef logic [6:0]   plru_t;              // tree bits of one set

    typedef logic [1:0] op_t;
    localparam op_t OP_READ  = 2'd0;
    localparam op_t OP_WRITE = 2'd1;
    localparam op_t OP_FILL  = 2'd2;   // code 3 acts as a read

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        UPDATE,
        DONE
    } ctrl_state_t;

endpackage

// File: src/cache_top.sv
`timescale 1ns/100ps

module cache_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  cache_pkg::op_t    op,
    input  cache_pkg::addr_t  addr,
    input  cache_pkg::line_t  wdata,
    output logic              ack,
    output cache_pkg::line_t  rdata,
    output logic              hit,
    output cache_pkg::way_t   way,
    output logic              dirty,
    output cache_pkg::addr_t  victim_addr
);

    way_access_if acc ();   // controller to storage

    cache_ctrl i_cache_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .rdata       (rdata),
        .hit         (hit),
        .way         (way),
        .dirty       (dirty),
        .victim_addr (victim_addr),
        .acc         (acc.ctrl)
    );

    meta_array i_meta_array (
        .clk   (clk),
        .rst_n (rst_n),
        .acc   (acc.meta)
    );

    data_array i_data_array (
        .clk (clk),
        .acc (acc.data)
    );

    plru_tree i_plru_tree (
        .clk   (clk),
        .rst_n (rst_n),
        .acc   (acc.lru)
    );

endmodule

// File: src/data_array.sv
`timescale 1ns/100ps

module data_array (
    input logic        clk,
    way_access_if.data acc
);
    import cache_pkg::*;

    line_t line_mem [NUM_WAYS][NUM_SETS];
    line_t line_q   [NUM_WAYS];   // addressed set, all ways

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            line_q[w] <= line_mem[w][acc.index];
            if (acc.wr_ways[w]) begin
                line_mem[w][acc.index] <= acc.wr_line;
            end
        end
    end

    // output way mux
    assign acc.rd_line = line_q[acc.sel_way];

endmodule

// File: src/meta_array.sv
`timescale 1ns/100ps

module meta_array (
    input logic        clk,
    input logic        rst_n,
    way_access_if.meta acc
);
    import cache_pkg::*;

    tag_t     tag_mem   [NUM_WAYS][NUM_SETS];
    way_vec_t valid_mem [NUM_SETS];   // bit per way
    way_vec_t dirty_mem [NUM_SETS];

    tag_t     tag_q [NUM_WAYS];
    way_vec_t valid_q;
    way_vec_t dirty_q;

    // tags
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            tag_q[w] <= tag_mem[w][acc.index];
            if (acc.wr_ways[w] && acc.wr_tag_en) begin
                tag_mem[w][acc.index] <= acc.tag;
            end
        end
    end

    // valid and dirty bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            valid_q <= valid_mem[acc.index];
            dirty_q <= dirty_mem[acc.index];
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (acc.wr_ways[w]) begin
                    if (acc.wr_tag_en) begin
                        valid_mem[acc.index][w] <= 1'b1;
                    end
                    dirty_mem[acc.index][w] <= acc.wr_dirty;
                end
            end
        end
    end

    // tag compare per way
    always_comb begin
        acc.hit_ways = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            acc.hit_ways[w] = valid_q[w] && (tag_q[w] == acc.tag);
        end
    end

    assign acc.sel_tag   = tag_q[acc.sel_way];
    assign acc.sel_dirty = dirty_q[acc.sel_way];

endmodule

// File: src/plru_tree.sv
`timescale 1ns/100ps

module plru_tree (
    input logic       clk,
    input logic       rst_n,
    way_access_if.lru acc
);
    import cache_pkg::*;

    plru_t tree_mem [NUM_SETS];
    plru_t tree_q;      // registered tree of the addressed set
    plru_t tree_next;

    logic  v_hi;
    logic  v_mid;
    logic  v_lo;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                tree_mem[s] <= '0;
            end
            tree_q <= '0;
        end else begin
            tree_q <= tree_mem[acc.index];
            if (acc.touch) begin
                tree_mem[acc.index] <= tree_next;
            end
        end
    end

    // point every node on the path away from sel_way
    always_comb begin
        tree_next = tree_mem[acc.index];
        tree_next[0] = ~acc.sel_way[2];
        tree_next[{2'b00, acc.sel_way[2]} + 3'd1] = ~acc.sel_way[1];
        tree_next[{1'b0, acc.sel_way[2:1]} + 3'd3] = ~acc.sel_way[0];
    end

    // walk from the root, 0 = lower half
    assign v_hi  = tree_q[0];
    assign v_mid = v_hi ? tree_q[2] : tree_q[1];
    assign v_lo  = tree_q[{1'b0, v_hi, v_mid} + 3'd3];

    assign acc.victim = {v_hi, v_mid, v_lo};

endmodule

// File: src/way_access_if.sv
`timescale 1ns/100ps

interface way_access_if;
    import cache_pkg::*;

    index_t   index;      // addressed set
    tag_t     tag;        // tag of the request
    way_t     sel_way;
    way_vec_t wr_ways;    // one-hot write strobe
    logic     wr_tag_en;
    logic     wr_dirty;
    line_t    wr_line;
    logic     touch;      // plru update for sel_way

    way_vec_t hit_ways;
    tag_t     sel_tag;
    logic     sel_dirty;
    line_t    rd_line;
    way_t     victim;

    modport ctrl (
        output index, tag, sel_way, wr_ways, wr_tag_en, wr_dirty, wr_line, touch,
        input  hit_ways, sel_tag, sel_dirty, rd_line, victim
    );

    modport meta (
        input  index, tag, sel_way, wr_ways, wr_tag_en, wr_dirty,
        output hit_ways, sel_tag, sel_dirty
    );

    modport data (input index, sel_way, wr_ways, wr_line, output rd_line);

    modport lru (input index, sel_way, touch, output victim);

endinterface
